/* riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Datapath width
`define XLEN 32

// Architectural register count, x0 included
`define NREGS 32

// Wishbone address width in bits
`define WB_AW 8

// Issue address, one instruction word per write
`define WB_ADDR_ISSUE 8'h00

// Register read window, byte addressed
// x<n> sits at base + 4*n
`define WB_ADDR_REG_BASE 8'h80

`endif

/* riscv_pkg.sv */
package riscv_pkg;

    `include "riscv_consts.svh"

    // Basic datapath types
    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

    // ALU operations of the kept subset
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // Where an ALU operand comes from
    typedef enum logic [1:0] {
        RS1,
        RS2,
        IMM,
        ZERO
    } alu_src_t;

    // Forwarding mux select
    // FORWARD_alu taps EX/MEM, FORWARD_wb taps MEM/WB
    typedef enum logic [1:0] {
        NOFORWARD,
        FORWARD_alu,
        FORWARD_wb
    } fwd_sel_t;

    // Decoded instruction plus operand values read at decode
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     reg_write;
        alu_op_t  alu_op;
        alu_src_t src_a;
        alu_src_t src_b;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
    } id_ex_t;

    // ALU result on its way to writeback
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        xlen_t    result;
    } ex_mem_t;

    // Same content one stage later
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        xlen_t    result;
    } mem_wb_t;

endpackage

/* bus_pkg.sv */
package bus_pkg;

    // Which address window a Wishbone cycle targets
    typedef enum logic [1:0] {
        ISSUE,
        REG,
        NONE
    } wb_win_t;

    // Register read handshake
    // RD_ACK lasts exactly one cycle
    typedef enum logic {
        RD_IDLE,
        RD_ACK
    } rd_state_t;

endpackage

/* fu.sv */
`timescale 1ns/1ps

module fu import riscv_pkg::*; (
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  alu_src_t src_a,
    input  alu_src_t src_b,
    input  logic     mem_valid,
    input  logic     mem_reg_write,
    input  reg_idx_t mem_rd,
    input  logic     wb_valid,
    input  logic     wb_reg_write,
    input  reg_idx_t wb_rd,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    // Younger producer in EX/MEM wins over MEM/WB
    // Each stage is qualified on its own valid, write enable and rd
    function automatic fwd_sel_t pick(input reg_idx_t rs);
        fwd_sel_t sel;
        sel = NOFORWARD;
        if (mem_valid && mem_reg_write && (mem_rd != '0) && (mem_rd == rs)) begin
            sel = FORWARD_alu;
        end else if (wb_valid && wb_reg_write && (wb_rd != '0) && (wb_rd == rs)) begin
            sel = FORWARD_wb;
        end
        return sel;
    endfunction

    always_comb begin
        // Operand A compares on rs1, operand B on rs2
        fwd_a = (src_a == RS1) ? pick(ex_rs1) : NOFORWARD;
        fwd_b = (src_b == RS2) ? pick(ex_rs2) : NOFORWARD;
    end

endmodule

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid instruction
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

/* wb_issue.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module wb_issue import riscv_pkg::*, bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [`WB_AW-1:0] adr,
    input  xlen_t             dat_w,
    output xlen_t             dat_r,
    output logic              ack,
    output reg_idx_t          rd_idx_a,
    output reg_idx_t          rd_idx_b,
    output reg_idx_t          host_idx,
    input  xlen_t             rd_val_a,
    input  xlen_t             rd_val_b,
    input  xlen_t             host_val,
    input  logic              pipe_busy,
    output logic              issue_valid,
    output id_ex_t            issue
);

    // Major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    wb_win_t           win;
    rd_state_t         rd_state;
    logic              req;
    logic              reg_read;
    logic [`WB_AW-1:0] reg_off;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              known;

    // Window decode, anything at or above the base is a register
    assign req     = cyc && stb;
    assign reg_off = adr - `WB_ADDR_REG_BASE;
    always_comb begin
        if (adr == `WB_ADDR_ISSUE) begin
            win = ISSUE;
        end else if (adr >= `WB_ADDR_REG_BASE) begin
            win = REG;
        end else begin
            win = NONE;
        end
    end

    // Register read waits for the pipeline to drain
    assign reg_read = req && !we && (win == REG);
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else if (rd_state == RD_ACK) begin
            rd_state <= RD_IDLE;
        end else if (reg_read && !pipe_busy) begin
            rd_state <= RD_ACK;
        end
    end

    // Everything but a register read acks at once
    assign ack      = req && (reg_read ? (rd_state == RD_ACK) : 1'b1);
    assign host_idx = reg_off[6:2];
    assign dat_r    = reg_read ? host_val : '0;

    // Instruction fields
    assign issue_valid = req && we && (win == ISSUE);
    assign opcode      = dat_w[6:0];
    assign funct3      = dat_w[14:12];
    assign funct7      = dat_w[31:25];
    assign rd_idx_a    = dat_w[19:15];
    assign rd_idx_b    = dat_w[24:20];

    always_comb begin
        issue.rs1     = dat_w[19:15];
        issue.rs2     = dat_w[24:20];
        issue.rd      = dat_w[11:7];
        issue.rs1_val = rd_val_a;
        issue.rs2_val = rd_val_b;
        // I-type immediate by default
        issue.imm     = {{20{dat_w[31]}}, dat_w[31:20]};
        issue.alu_op  = ALU_ADD;
        issue.src_a   = RS1;
        issue.src_b   = IMM;
        known         = 1'b0;
        case (opcode)
            OPC_OP: begin
                issue.src_b = RS2;
                // SUB and SRA are the only funct7=0x20 forms
                if (funct7 == 7'h00) begin
                    known = (funct3 != 3'b011);
                    case (funct3)
                        3'b000:  issue.alu_op = ALU_ADD;
                        3'b001:  issue.alu_op = ALU_SLL;
                        3'b010:  issue.alu_op = ALU_SLT;
                        3'b100:  issue.alu_op = ALU_XOR;
                        3'b101:  issue.alu_op = ALU_SRL;
                        3'b110:  issue.alu_op = ALU_OR;
                        default: issue.alu_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'h20) begin
                    known = (funct3 == 3'b000) || (funct3 == 3'b101);
                    issue.alu_op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                // No shift immediates, no SLTIU
                known = 1'b1;
                case (funct3)
                    3'b000:  issue.alu_op = ALU_ADD;
                    3'b010:  issue.alu_op = ALU_SLT;
                    3'b100:  issue.alu_op = ALU_XOR;
                    3'b110:  issue.alu_op = ALU_OR;
                    3'b111:  issue.alu_op = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_LUI: begin
                // 0 + upper immediate
                known       = 1'b1;
                issue.src_a = ZERO;
                issue.imm   = {dat_w[31:12], 12'h000};
            end
            default: known = 1'b0;
        endcase
        // Unknown words flow through as NOPs
        issue.reg_write = known && (issue.rd != '0);
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module regfile import riscv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_val,
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    input  reg_idx_t rh,
    output xlen_t    va,
    output xlen_t    vb,
    output xlen_t    vh
);

    // x0 has no storage
    xlen_t regs [1:`NREGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_val;
        end
    end

    // Pipeline read with same-cycle write bypass
    function automatic xlen_t rd_bypass(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (we && (wr_idx == idx)) begin
            return wr_val;
        end
        return regs[idx];
    endfunction

    assign va = rd_bypass(ra);
    assign vb = rd_bypass(rb);
    // Host only reads a drained pipeline
    assign vh = (rh == '0) ? '0 : regs[rh];

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import riscv_pkg::*; (
    input  id_ex_t   id,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  xlen_t    mem_result,
    input  xlen_t    wb_result,
    output ex_mem_t  ex
);

    xlen_t reg_a;
    xlen_t reg_b;
    xlen_t op_a;
    xlen_t op_b;

    // Forwarded register values
    always_comb begin
        case (fwd_a)
            FORWARD_alu: reg_a = mem_result;
            FORWARD_wb:  reg_a = wb_result;
            default:     reg_a = id.rs1_val;
        endcase
        case (fwd_b)
            FORWARD_alu: reg_b = mem_result;
            FORWARD_wb:  reg_b = wb_result;
            default:     reg_b = id.rs2_val;
        endcase
    end

    // Operand source muxes
    always_comb begin
        case (id.src_a)
            RS1:     op_a = reg_a;
            IMM:     op_a = id.imm;
            default: op_a = '0;
        endcase
        case (id.src_b)
            RS2:     op_b = reg_b;
            IMM:     op_b = id.imm;
            default: op_b = '0;
        endcase
    end

    // ALU, shift amount is the low 5 bits
    always_comb begin
        ex.rd        = id.rd;
        ex.reg_write = id.reg_write;
        case (id.alu_op)
            ALU_SUB: ex.result = op_a - op_b;
            ALU_AND: ex.result = op_a & op_b;
            ALU_OR:  ex.result = op_a | op_b;
            ALU_XOR: ex.result = op_a ^ op_b;
            ALU_SLT: ex.result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_SLL: ex.result = op_a << op_b[4:0];
            ALU_SRL: ex.result = op_a >> op_b[4:0];
            ALU_SRA: ex.result = $signed(op_a) >>> op_b[4:0];
            default: ex.result = op_a + op_b;
        endcase
    end

endmodule

/* riscv_ex_top.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module riscv_ex_top import riscv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [`WB_AW-1:0] adr,
    input  xlen_t             dat_w,
    output xlen_t             dat_r,
    output logic              ack
);

    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    reg_idx_t host_idx;
    xlen_t    rd_val_a;
    xlen_t    rd_val_b;
    xlen_t    host_val;
    logic     pipe_busy;
    logic     issue_valid;
    id_ex_t   issue;
    logic     id_valid;
    id_ex_t   id_data;
    ex_mem_t  ex_data;
    logic     mem_valid;
    ex_mem_t  mem_data;
    mem_wb_t  mem_pass;
    logic     wb_valid;
    mem_wb_t  wb_data;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     rf_we;

    // Reads stall until no stage holds an instruction
    assign pipe_busy = id_valid | mem_valid | wb_valid;

    // Memory stage only carries the result along
    assign mem_pass.rd        = mem_data.rd;
    assign mem_pass.reg_write = mem_data.reg_write;
    assign mem_pass.result    = mem_data.result;

    // Writeback port
    assign rf_we = wb_valid & wb_data.reg_write;

    wb_issue i_wb_issue (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .rd_idx_a, .rd_idx_b, .host_idx,
        .rd_val_a, .rd_val_b, .host_val,
        .pipe_busy, .issue_valid, .issue
    );

    regfile i_regfile (
        .clk, .rst_n,
        .we(rf_we), .wr_idx(wb_data.rd), .wr_val(wb_data.result),
        .ra(rd_idx_a), .rb(rd_idx_b), .rh(host_idx),
        .va(rd_val_a), .vb(rd_val_b), .vh(host_val)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk, .rst_n, .in_valid(issue_valid), .in_data(issue),
        .out_valid(id_valid), .out_data(id_data)
    );

    fu i_fu (
        .ex_rs1(id_data.rs1), .ex_rs2(id_data.rs2),
        .src_a(id_data.src_a), .src_b(id_data.src_b),
        .mem_valid, .mem_reg_write(mem_data.reg_write), .mem_rd(mem_data.rd),
        .wb_valid, .wb_reg_write(wb_data.reg_write), .wb_rd(wb_data.rd),
        .fwd_a, .fwd_b
    );

    ex_stage i_ex_stage (
        .id(id_data), .fwd_a, .fwd_b,
        .mem_result(mem_data.result), .wb_result(wb_data.result),
        .ex(ex_data)
    );

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk, .rst_n, .in_valid(id_valid), .in_data(ex_data),
        .out_valid(mem_valid), .out_data(mem_data)
    );

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk, .rst_n, .in_valid(mem_valid), .in_data(mem_pass),
        .out_valid(wb_valid), .out_data(wb_data)
    );

endmodule

/* riscv_ex_assertions.sv */
`timescale 1ns/1ps

module riscv_ex_assertions import riscv_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     cyc,
    input logic     stb,
    input logic     ack,
    input logic     rf_we,
    input mem_wb_t  wb_data,
    input fwd_sel_t fwd_a,
    input logic     mem_valid,
    input ex_mem_t  mem_data
);

    // Slave only answers an active request
    ack_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb)
    ) else $error("ack seen without cyc and stb");

    // x0 must never be targeted by the write port
    no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n) rf_we |-> (wb_data.rd != '0)
    ) else $error("register file write to x0");

    // EX/MEM forward needs a live, writing producer
    fwd_a_from_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fwd_a == FORWARD_alu) |-> (mem_valid && mem_data.reg_write)
    ) else $error("operand A forwarded from an idle EX/MEM stage");

endmodule

/* tb_riscv_ex.sv */
`timescale 1ns/1ps
`include "riscv_consts.svh"

module tb_riscv_ex import riscv_pkg::*, bus_pkg::*; ();

    localparam int ACK_TIMEOUT = 20;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`WB_AW-1:0] adr;
    xlen_t             dat_w;
    xlen_t             dat_r;
    logic              ack;

    riscv_ex_top i_riscv_ex_top (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
    );

    bind riscv_ex_top riscv_ex_assertions i_assertions (
        .clk, .rst_n, .cyc, .stb, .ack, .rf_we, .wb_data,
        .fwd_a, .mem_valid, .mem_data
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // Bus address of each window, straight from the address map
    function automatic logic [`WB_AW-1:0] addr_for(input wb_win_t win, input reg_idx_t idx);
        case (win)
            ISSUE:   return `WB_ADDR_ISSUE;
            REG:     return `WB_ADDR_REG_BASE + {1'b0, idx, 2'b00};
            default: return 8'h40;
        endcase
    endfunction

    task automatic check_reg(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "register value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "control signal mismatch");
        end
    endtask

    task automatic bad_line(input int lineno);
        $display("trace line %0d could not be parsed", lineno);
        $display("TESTBENCH FAILED");
        $fatal(1, "bad trace");
    endtask

    // Sample ack at the falling edge, where it has settled
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ack) begin
            if (cycles == ACK_TIMEOUT) begin
                $display("no Wishbone acknowledge within %0d cycles", ACK_TIMEOUT);
                $display("TESTBENCH FAILED");
                $fatal(1, "bus timeout");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Request stays up so the next word can follow at the next edge
    task automatic bus_issue(input xlen_t word);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= addr_for(ISSUE, '0);
        dat_w <= word;
        wait_ack();
    endtask

    task automatic bus_read(input logic [`WB_AW-1:0] a, output xlen_t val);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_ack();
        val = dat_r;
    endtask

    // Drop the request for n cycles
    task automatic idle(input int n);
        if (n > 0) begin
            @(posedge clk);
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
            repeat (n - 1) @(posedge clk);
        end
    endtask

    initial begin
        string    line;
        int       fd;
        int       lineno;
        int       fields;
        int       idx;
        logic [7:0] kind;
        xlen_t    word;
        xlen_t    expect_val;
        xlen_t    got;

        rst_n <= 1'b0;
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= '0;
        dat_w <= '0;
        void'($urandom(32'h6d3d6797));
        lineno = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // First request out of reset is a register read
        // Its registered ack must not show in the first cycle
        cyc   <= 1'b1;
        stb   <= 1'b1;
        adr   <= addr_for(REG, '0);
        @(negedge clk);
        check_flag("read ack after reset", 1'b0, ack);
        wait_ack();
        check_reg("x0 after reset", '0, dat_r);

        fd = $fopen("riscv_ex_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file riscv_ex_trace.txt not found");
            $display("TESTBENCH FAILED");
            $fatal(1, "no trace");
        end

        while ($fgets(line, fd) != 0) begin
            lineno++;
            // Skip blanks and comments
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "I") begin
                fields = $sscanf(line, "%c %h", kind, word);
                if (fields != 2) bad_line(lineno);
                else bus_issue(word);
            end else if (line[0] == "R") begin
                fields = $sscanf(line, "%c %d %h", kind, idx, expect_val);
                if (fields != 3) begin
                    bad_line(lineno);
                end else begin
                    // Issued right after a burst, so it must wait for the drain
                    bus_read(addr_for(REG, reg_idx_t'(idx)), got);
                    check_reg($sformatf("trace line %0d x%0d", lineno, idx), expect_val, got);
                    idle($urandom_range(2, 0));
                end
            end else begin
                bad_line(lineno);
            end
        end
        $fclose(fd);

        // Unmapped window reads as zero
        bus_read(addr_for(NONE, '0), got);
        check_reg("unmapped read", '0, got);
        idle(1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* riscv_ex_trace.txt */
# I <instruction word hex>            issue one instruction
# R <register index> <expected hex>   read a register and compare
# after reset
R 1 00000000
R 31 00000000
# independent ADDI, LUI, XORI
I 00500093
I FFD00113
I 123451B7
I 7FF04213
R 1 00000005
R 2 FFFFFFFD
R 3 12345000
R 4 000007FF
# distance 1 chain on A and on B
I 001083B3
I 001383B3
I 007083B3
I 00738433
R 7 00000014
R 8 00000028
# distance 2 and distance 3 with NOP fillers
I 401384B3
I 00000013
I 00149533
I 00000013
I 00000013
I 002545B3
I 4015D633
R 9 0000000F
R 10 000001E0
R 11 FFFFFE1D
R 12 FFFFFFF0
# x13 in MEM and WB at once
I 00100693
I 00200693
I 00D68733
R 14 00000004
R 13 00000002
# write to x0, unsupported opcode with rd=x1
I 07B00013
I 7FF0008B
I 001007B3
R 0 00000000
R 1 00000005
R 15 00000005
# read right behind the producer
I 00108093
R 1 00000006

/* list.f */
+incdir+.
riscv_pkg.sv
bus_pkg.sv
fu.sv
pipe_reg.sv
wb_issue.sv
regfile.sv
ex_stage.sv
riscv_ex_top.sv
riscv_ex_assertions.sv
tb_riscv_ex.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_riscv_ex
FLIST     = list.f

SRCS = $(filter-out +%,$(shell cat $(FLIST))) riscv_consts.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
